//--- source/bp_pkg.sv
package bp_pkg;

    // Table geometry and datapath widths
    localparam int index_bits_c = 4;
    localparam int table_depth_c = 16;
    localparam int xlen_c = 32;
    localparam int mispredict_count_w_c = 16;

    // Host register map
    localparam logic cfg_addr_mode_c = 1'b0;
    localparam logic cfg_addr_count_c = 1'b1;

    // Prediction mode, 11 falls back to dynamic
    typedef enum logic [1:0] {
        mode_static_nt = 2'b00,
        mode_btfn      = 2'b01,
        mode_dynamic   = 2'b10
    } bp_mode_t;

    // Two-bit counter, upper bit is the prediction
    typedef enum logic [1:0] {
        strong_untaken = 2'b00,
        weak_untaken   = 2'b01,
        weak_taken     = 2'b10,
        strong_taken   = 2'b11
    } ctr_state_t;

    // One fetched word from the fetch stage
    typedef struct packed {
        logic              valid;
        logic [xlen_c-1:0] pc;
        logic [31:0]       instr;
    } fetch_req_t;

    // Registered prediction towards fetch
    typedef struct packed {
        logic              valid;
        logic              is_ctrl;
        logic              taken;
        logic [xlen_c-1:0] target;
    } bp_pred_t;

    // Resolved outcome from execute
    typedef struct packed {
        logic              valid;
        logic [xlen_c-1:0] pc;
        logic              taken_resolved;
        logic              predicted_taken;
    } bp_update_t;

    // Host access, stable while req is high
    typedef struct packed {
        logic                            write;
        logic                            addr;
        logic [mispredict_count_w_c-1:0] wdata;
    } cfg_req_t;

endpackage

//--- source/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes of interest to predecode
    localparam logic [6:0] opcode_branch_c = 7'b1100011;
    localparam logic [6:0] opcode_jal_c = 7'b1101111;

    // Conditional branch layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    // JAL layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // Same 32-bit word, two field views
    // Opcode sits at bits 6:0 in both
    typedef union packed {
        b_type_t b;
        j_type_t j;
    } instr_word_u;

endpackage

//--- source/local_predictor.sv
module local_predictor (
    input  logic clk_i,
    input  logic reset_i,
    // Resolved direction from execute
    input  logic pc_src_res_e_i,
    // Only this entry's update moves the counter
    input  logic enable_i,
    output logic pc_src_pred_o
);

    bp_pkg::ctr_state_t state_q;
    bp_pkg::ctr_state_t state_d;

    // Step one place toward the resolved direction, saturating at both ends
    always_comb begin
        state_d = state_q;
        case (state_q)
            bp_pkg::strong_taken: begin
                state_d = pc_src_res_e_i ? bp_pkg::strong_taken : bp_pkg::weak_taken;
            end
            bp_pkg::weak_taken: begin
                state_d = pc_src_res_e_i ? bp_pkg::strong_taken : bp_pkg::weak_untaken;
            end
            bp_pkg::weak_untaken: begin
                state_d = pc_src_res_e_i ? bp_pkg::weak_taken : bp_pkg::strong_untaken;
            end
            bp_pkg::strong_untaken: begin
                state_d = pc_src_res_e_i ? bp_pkg::weak_untaken : bp_pkg::strong_untaken;
            end
            default: begin
                state_d = bp_pkg::weak_untaken;
            end
        endcase
    end

    // Start out leaning not-taken
    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            state_q <= bp_pkg::weak_untaken;
        end else if (enable_i) begin
            state_q <= state_d;
        end
    end

    // Upper bit set means taken
    assign pc_src_pred_o = state_q[1];

endmodule

//--- source/predictor_table.sv
module predictor_table (
    input  logic                              clk_i,
    input  logic                              reset_i,
    // Training from execute
    input  bp_pkg::bp_update_t                update_i,
    // Lookup from predecode
    input  logic [bp_pkg::index_bits_c-1:0]   rd_index_i,
    output logic                              dyn_taken_o
);

    // Update index taken from PC word bits, byte offset dropped
    logic [bp_pkg::index_bits_c-1:0]  upd_index;
    logic [bp_pkg::table_depth_c-1:0] upd_en;
    logic [bp_pkg::table_depth_c-1:0] ctr_taken;

    assign upd_index = update_i.pc[bp_pkg::index_bits_c+1:2];

    for (genvar i = 0; i < bp_pkg::table_depth_c; i++) begin : g_ctr
        localparam logic [bp_pkg::index_bits_c-1:0] entry_c = i;

        // One-hot enable, gated by update valid
        assign upd_en[i] = update_i.valid && (upd_index == entry_c);

        // Resolved direction is broadcast, enable picks the entry
        local_predictor u_ctr (
            .clk_i          (clk_i),
            .reset_i        (reset_i),
            .pc_src_res_e_i (update_i.taken_resolved),
            .enable_i       (upd_en[i]),
            .pc_src_pred_o  (ctr_taken[i])
        );
    end

    // Read is combinational
    // Shows the old state when an update lands on the same edge
    assign dyn_taken_o = ctr_taken[rd_index_i];

endmodule

//--- source/branch_predecoder.sv
module branch_predecoder (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  bp_pkg::fetch_req_t              fetch_i,
    input  bp_pkg::bp_mode_t                mode_i,
    // Counter prediction for rd_index_o
    input  logic                            dyn_taken_i,
    output logic [bp_pkg::index_bits_c-1:0] rd_index_o,
    output bp_pkg::bp_pred_t                pred_o
);

    rv_isa_pkg::instr_word_u       instr_w;
    logic                          is_branch;
    logic                          is_jal;
    logic [bp_pkg::xlen_c-1:0]     b_imm;
    logic [bp_pkg::xlen_c-1:0]     j_imm;
    logic [bp_pkg::xlen_c-1:0]     target_d;
    logic                          branch_taken;
    bp_pkg::bp_pred_t              pred_d;

    // Raw word seen through both field layouts
    assign instr_w = fetch_i.instr;

    // Opcode occupies the same bits in either view
    assign is_branch = (instr_w.b.opcode == rv_isa_pkg::opcode_branch_c);
    assign is_jal = (instr_w.j.opcode == rv_isa_pkg::opcode_jal_c);

    // B-type offset, 13 bits signed, bit 0 always zero
    assign b_imm = {{19{instr_w.b.imm12}}, instr_w.b.imm12, instr_w.b.imm11,
                    instr_w.b.imm10_5, instr_w.b.imm4_1, 1'b0};

    // J-type offset, 21 bits signed
    assign j_imm = {{11{instr_w.j.imm20}}, instr_w.j.imm20, instr_w.j.imm19_12,
                    instr_w.j.imm11, instr_w.j.imm10_1, 1'b0};

    // Fall-through for anything not a branch or jump
    always_comb begin
        if (is_jal) begin
            target_d = fetch_i.pc + j_imm;
        end else if (is_branch) begin
            target_d = fetch_i.pc + b_imm;
        end else begin
            target_d = fetch_i.pc + 32'd4;
        end
    end

    // Conditional branch direction per mode
    always_comb begin
        case (mode_i)
            bp_pkg::mode_static_nt: branch_taken = 1'b0;
            // Backward offsets are usually loops
            bp_pkg::mode_btfn:      branch_taken = instr_w.b.imm12;
            // Dynamic and the spare encoding both use the table
            default:                branch_taken = dyn_taken_i;
        endcase
    end

    // Table lookup on PC word bits
    assign rd_index_o = fetch_i.pc[bp_pkg::index_bits_c+1:2];

    always_comb begin
        pred_d.valid = fetch_i.valid;
        pred_d.is_ctrl = is_branch || is_jal;
        // JAL always redirects
        pred_d.taken = is_jal || (is_branch && branch_taken);
        pred_d.target = target_d;
    end

    // Loads every cycle, no stall path
    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            pred_o <= '0;
        end else begin
            pred_o <= pred_d;
        end
    end

endmodule

//--- source/bp_config_regs.sv
module bp_config_regs (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    // Four-phase host port
    input  logic                                    cfg_req_i,
    input  bp_pkg::cfg_req_t                        cfg_i,
    output logic                                    cfg_ack_o,
    output logic [bp_pkg::mispredict_count_w_c-1:0] cfg_rdata_o,
    // Resolved outcomes, for the mispredict count
    input  bp_pkg::bp_update_t                      update_i,
    output bp_pkg::bp_mode_t                        mode_o
);

    logic                                    req_q;
    logic                                    ack_q;
    logic                                    access_fire;
    logic                                    mispredict;
    logic [bp_pkg::mispredict_count_w_c-1:0] count_q;
    logic [bp_pkg::mispredict_count_w_c-1:0] rdata_q;
    bp_pkg::bp_mode_t                        mode_q;

    // Registered req, the access happens one cycle after it is seen high
    assign access_fire = req_q && !ack_q;

    // Prediction disagreed with the resolved direction
    assign mispredict = update_i.valid &&
                        (update_i.taken_resolved != update_i.predicted_taken);

    // Handshake state
    // ack rises with the access and drops a cycle after req is seen low
    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            req_q <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            req_q <= cfg_req_i;
            if (access_fire) begin
                ack_q <= 1'b1;
            end else if (!req_q) begin
                ack_q <= 1'b0;
            end
        end
    end

    // Mode register, low two bits of the write data
    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            mode_q <= bp_pkg::mode_dynamic;
        end else if (access_fire && cfg_i.write && cfg_i.addr == bp_pkg::cfg_addr_mode_c) begin
            mode_q <= bp_pkg::bp_mode_t'(cfg_i.wdata[1:0]);
        end
    end

    // Mispredict counter
    // Host write clears it, which wins over a same-cycle increment
    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (access_fire && cfg_i.write && cfg_i.addr == bp_pkg::cfg_addr_count_c) begin
            count_q <= '0;
        end else if (mispredict && !(&count_q)) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Read data captured with the access, held while ack is up
    always_ff @(posedge clk_i) begin
        if (access_fire && !cfg_i.write) begin
            if (cfg_i.addr == bp_pkg::cfg_addr_mode_c) begin
                rdata_q <= {{(bp_pkg::mispredict_count_w_c-2){1'b0}}, mode_q};
            end else begin
                rdata_q <= count_q;
            end
        end
    end

    assign cfg_ack_o = ack_q;
    assign cfg_rdata_o = rdata_q;
    assign mode_o = mode_q;

endmodule

//--- source/branch_prediction_unit.sv
module branch_prediction_unit (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    // Fetch side
    input  bp_pkg::fetch_req_t                      fetch_i,
    // Execute side
    input  bp_pkg::bp_update_t                      update_i,
    // Host register port
    input  logic                                    cfg_req_i,
    input  bp_pkg::cfg_req_t                        cfg_i,
    output logic                                    cfg_ack_o,
    output logic [bp_pkg::mispredict_count_w_c-1:0] cfg_rdata_o,
    // Prediction, one cycle after fetch
    output bp_pkg::bp_pred_t                        pred_o
);

    bp_pkg::bp_mode_t                mode;
    logic [bp_pkg::index_bits_c-1:0] rd_index;
    logic                            dyn_taken;

    // Mode register and mispredict count
    bp_config_regs u_cfg (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cfg_req_i   (cfg_req_i),
        .cfg_i       (cfg_i),
        .cfg_ack_o   (cfg_ack_o),
        .cfg_rdata_o (cfg_rdata_o),
        .update_i    (update_i),
        .mode_o      (mode)
    );

    // Decode, target add and decision
    branch_predecoder u_predecode (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .fetch_i     (fetch_i),
        .mode_i      (mode),
        .dyn_taken_i (dyn_taken),
        .rd_index_o  (rd_index),
        .pred_o      (pred_o)
    );

    // Counters trained by execute
    predictor_table u_table (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .update_i    (update_i),
        .rd_index_i  (rd_index),
        .dyn_taken_o (dyn_taken)
    );

endmodule

//--- sim/bp_properties.sv
module bp_properties (
    input logic             clk_i,
    input logic             reset_i,
    // Host handshake, tied low where bound without a config port
    input logic             req_i,
    input logic             ack_i,
    // Prediction valid, tied low where bound without one
    input logic             pred_valid_i,
    input bp_pkg::bp_mode_t mode_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // ack only answers a request seen on the previous edge
    ack_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(ack_i) |-> $past(req_i))
        else $error("cfg ack rose with no request pending");

    // ack drops only once the host has let go of req
    ack_falls_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
        $fell(ack_i) |-> !$past(req_i))
        else $error("cfg ack fell while req was still high");

    // Reset state, quiet outputs and dynamic mode
    reset_state: assert property (@(posedge clk_i)
        reset_i |-> (!pred_valid_i && !ack_i && mode_i == bp_pkg::mode_dynamic))
        else $error("outputs or mode not at reset values during reset");

endmodule

// Handshake side
bind bp_config_regs bp_properties u_cfg_props (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (cfg_req_i),
    .ack_i        (cfg_ack_o),
    .pred_valid_i (1'b0),
    .mode_i       (mode_o)
);

// Prediction side
bind branch_predecoder bp_properties u_pred_props (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (1'b0),
    .ack_i        (1'b0),
    .pred_valid_i (pred_o.valid),
    .mode_i       (mode_i)
);

//--- sim/bp_tb.sv
module bp_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles_c = 2000;
    localparam int ack_wait_c = 20;
    localparam int cw_c = bp_pkg::mispredict_count_w_c;
    // addi x1, x1, 1
    localparam logic [31:0] alu_instr_c = 32'h00108093;
    // Offsets span both ends of each immediate range
    localparam int branch_offs_c [4] = '{-4096, 4094, -100, 36};
    localparam int jal_offs_c [4] = '{-1048576, 1048574, 2048, -8};

    logic               clk_i;
    logic               reset_i;
    bp_pkg::fetch_req_t fetch;
    bp_pkg::bp_update_t update;
    logic               cfg_req;
    bp_pkg::cfg_req_t   cfg;
    logic               cfg_ack;
    logic [cw_c-1:0]    cfg_rdata;
    bp_pkg::bp_pred_t   pred;

    int errors = 0;
    int err_mark = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;
    int seed = 70;

    branch_prediction_unit dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .fetch_i     (fetch),
        .update_i    (update),
        .cfg_req_i   (cfg_req),
        .cfg_i       (cfg),
        .cfg_ack_o   (cfg_ack),
        .cfg_rdata_o (cfg_rdata),
        .pred_o      (pred)
    );

    // 4 ns clock
    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Watchdog
    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles_c) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // B-type encoding, offset bit 0 dropped
    function automatic logic [31:0] make_branch(input int off);
        logic [31:0] w;
        w = 32'b0;
        w[31] = off[12];
        w[30:25] = off[10:5];
        w[24:20] = 5'd2;
        w[19:15] = 5'd1;
        w[11:8] = off[4:1];
        w[7] = off[11];
        w[6:0] = 7'b1100011;
        return w;
    endfunction

    // J-type encoding, rd = x1
    function automatic logic [31:0] make_jal(input int off);
        logic [31:0] w;
        w[31] = off[20];
        w[30:21] = off[10:1];
        w[20] = off[11];
        w[19:12] = off[19:12];
        w[11:7] = 5'd1;
        w[6:0] = 7'b1101111;
        return w;
    endfunction

    // Word-aligned PC with chosen table index
    function automatic logic [31:0] pc_at(input logic [3:0] idx);
        logic [31:0] r;
        r = $random(seed);
        r[5:2] = idx;
        r[1:0] = 2'b00;
        return r;
    endfunction

    function automatic bp_pkg::bp_pred_t expect_pred(input logic is_ctrl, input logic taken,
                                                     input logic [31:0] target);
        bp_pkg::bp_pred_t p;
        p.valid = 1'b1;
        p.is_ctrl = is_ctrl;
        p.taken = taken;
        p.target = target;
        return p;
    endfunction

    // One fetch word, prediction sampled after the next edge
    task automatic fetch_one(input logic [31:0] pc, input logic [31:0] instr,
                             output bp_pkg::bp_pred_t got);
        fetch.valid = 1'b1;
        fetch.pc = pc;
        fetch.instr = instr;
        @(posedge clk_i);
        #1;
        got = pred;
        fetch.valid = 1'b0;
    endtask

    task automatic send_update(input logic [31:0] pc, input logic taken, input logic predicted);
        update.valid = 1'b1;
        update.pc = pc;
        update.taken_resolved = taken;
        update.predicted_taken = predicted;
        @(posedge clk_i);
        #1;
        update.valid = 1'b0;
    endtask

    // Full four-phase cycle, ack must rise then fall
    task automatic cfg_access(input logic write, input logic addr, input logic [cw_c-1:0] wdata,
                              output logic [cw_c-1:0] rdata);
        int waited;
        waited = 0;
        rdata = '0;
        cfg.write = write;
        cfg.addr = addr;
        cfg.wdata = wdata;
        cfg_req = 1'b1;
        while (!cfg_ack && waited < ack_wait_c) begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (!cfg_ack) begin
            errors++;
            $display("Config access at %0t got no ack while req was high", $time);
        end else begin
            rdata = cfg_rdata;
        end
        cfg_req = 1'b0;
        waited = 0;
        while (cfg_ack && waited < ack_wait_c) begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (cfg_ack) begin
            errors++;
            $display("Config ack at %0t stayed high after req was dropped", $time);
        end
    endtask

    task automatic check_pred(input string what, input bp_pkg::bp_pred_t got,
                              input bp_pkg::bp_pred_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t pred_o (%s): got v%b c%b t%b %h, expected v%b c%b t%b %h",
                     $time, what, got.valid, got.is_ctrl, got.taken, got.target,
                     exp.valid, exp.is_ctrl, exp.taken, exp.target);
        end
    endtask

    task automatic check_rdata(input string what, input logic [cw_c-1:0] got,
                               input logic [cw_c-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t cfg_rdata_o (%s): got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("%-16s ok", name);
        end else begin
            tests_failed++;
            $display("%-16s failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // Fresh table, dynamic mode
    task automatic test_defaults();
        bp_pkg::bp_pred_t got;
        logic [31:0] pc;
        int i;
        check_pred("idle after reset", pred, '0);
        for (i = 0; i < 4; i++) begin
            pc = pc_at(4'($random(seed)));
            fetch_one(pc, make_branch(branch_offs_c[i]), got);
            check_pred("branch", got, expect_pred(1'b1, 1'b0, pc + branch_offs_c[i]));
            fetch_one(pc, make_jal(jal_offs_c[i]), got);
            check_pred("jal", got, expect_pred(1'b1, 1'b1, pc + jal_offs_c[i]));
            fetch_one(pc, alu_instr_c, got);
            check_pred("alu", got, expect_pred(1'b0, 1'b0, pc + 32'd4));
        end
    endtask

    task automatic test_training();
        bp_pkg::bp_pred_t got;
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        pc_a = pc_at(4'd3);
        // Index 12 shares no bits with 3
        pc_b = pc_at(4'd12);
        send_update(pc_a, 1'b1, 1'b0);
        send_update(pc_a, 1'b1, 1'b1);
        fetch_one(pc_a, make_branch(-32), got);
        check_pred("two taken", got, expect_pred(1'b1, 1'b1, pc_a - 32'd32));
        fetch_one(pc_b, make_branch(-32), got);
        check_pred("other index", got, expect_pred(1'b1, 1'b0, pc_b - 32'd32));
        send_update(pc_a, 1'b0, 1'b1);
        fetch_one(pc_a, make_branch(-32), got);
        check_pred("one not-taken", got, expect_pred(1'b1, 1'b1, pc_a - 32'd32));
        send_update(pc_a, 1'b0, 1'b1);
        send_update(pc_a, 1'b0, 1'b0);
        fetch_one(pc_a, make_branch(-32), got);
        check_pred("three not-taken", got, expect_pred(1'b1, 1'b0, pc_a - 32'd32));
    endtask

    task automatic test_saturation();
        bp_pkg::bp_pred_t got;
        logic [31:0] pc;
        pc = pc_at(4'd9);
        repeat (5) send_update(pc, 1'b1, 1'b1);
        send_update(pc, 1'b0, 1'b1);
        fetch_one(pc, make_branch(8), got);
        check_pred("saturated", got, expect_pred(1'b1, 1'b1, pc + 32'd8));
        // Second not-taken crosses to the untaken half
        send_update(pc, 1'b0, 1'b1);
        fetch_one(pc, make_branch(8), got);
        check_pred("after two", got, expect_pred(1'b1, 1'b0, pc + 32'd8));
    endtask

    task automatic test_modes();
        bp_pkg::bp_pred_t got;
        logic [cw_c-1:0] rd;
        logic [31:0] pc;
        pc = pc_at(4'd5);
        send_update(pc, 1'b1, 1'b0);
        send_update(pc, 1'b1, 1'b1);
        fetch_one(pc, make_branch(64), got);
        check_pred("dynamic trained", got, expect_pred(1'b1, 1'b1, pc + 32'd64));
        // Static not-taken ignores the table
        cfg_access(1'b1, 1'b0, 16'd0, rd);
        fetch_one(pc, make_branch(64), got);
        check_pred("static fwd", got, expect_pred(1'b1, 1'b0, pc + 32'd64));
        fetch_one(pc, make_branch(-64), got);
        check_pred("static back", got, expect_pred(1'b1, 1'b0, pc - 32'd64));
        fetch_one(pc, make_jal(-8), got);
        check_pred("static jal", got, expect_pred(1'b1, 1'b1, pc - 32'd8));
        cfg_access(1'b0, 1'b0, 16'd0, rd);
        check_rdata("mode static", rd, 16'd0);
        // Backward taken, forward not
        cfg_access(1'b1, 1'b0, 16'd1, rd);
        fetch_one(pc, make_branch(-64), got);
        check_pred("btfn back", got, expect_pred(1'b1, 1'b1, pc - 32'd64));
        fetch_one(pc, make_branch(64), got);
        check_pred("btfn fwd", got, expect_pred(1'b1, 1'b0, pc + 32'd64));
        cfg_access(1'b0, 1'b0, 16'd0, rd);
        check_rdata("mode btfn", rd, 16'd1);
        cfg_access(1'b1, 1'b0, 16'd2, rd);
        cfg_access(1'b0, 1'b0, 16'd0, rd);
        check_rdata("mode dynamic", rd, 16'd2);
        fetch_one(pc, make_branch(64), got);
        check_pred("dynamic again", got, expect_pred(1'b1, 1'b1, pc + 32'd64));
    endtask

    task automatic test_mispredict();
        logic [cw_c-1:0] rd;
        logic [31:0] pc;
        pc = pc_at(4'd14);
        cfg_access(1'b1, 1'b1, 16'd0, rd);
        cfg_access(1'b0, 1'b1, 16'd0, rd);
        check_rdata("count cleared", rd, 16'd0);
        // Four mismatches among six outcomes
        send_update(pc, 1'b1, 1'b0);
        send_update(pc, 1'b1, 1'b1);
        send_update(pc, 1'b0, 1'b1);
        send_update(pc, 1'b0, 1'b0);
        send_update(pc, 1'b1, 1'b0);
        send_update(pc, 1'b0, 1'b1);
        cfg_access(1'b0, 1'b1, 16'd0, rd);
        check_rdata("count four", rd, 16'd4);
        cfg_access(1'b1, 1'b1, 16'd0, rd);
        cfg_access(1'b0, 1'b1, 16'd0, rd);
        check_rdata("count reclear", rd, 16'd0);
    endtask

    initial begin
        reset_i = 1'b1;
        fetch = '0;
        update = '0;
        cfg_req = 1'b0;
        cfg = '0;
        repeat (3) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        test_defaults();
        report_test("reset_defaults");
        test_training();
        report_test("training");
        test_saturation();
        report_test("saturation");
        test_modes();
        report_test("modes");
        test_mispredict();
        report_test("mispredict");
        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- branch_prediction_unit.f
source/bp_pkg.sv
source/rv_isa_pkg.sv
source/local_predictor.sv
source/predictor_table.sv
source/branch_predecoder.sv
source/bp_config_regs.sv
source/branch_prediction_unit.sv
sim/bp_properties.sv
sim/bp_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the branch prediction unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module bp_tb \
    -f branch_prediction_unit.f \
    -o Vbp_tb

./obj_dir/Vbp_tb | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
